//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_serial_bus_system
FILELIST = serial_bus_system.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- common/bus_pkg.sv
/*
 * Shared widths, opcodes and FSM state encodings for the serial memory bus.
 * Host request, response and display digit structs.
 * Seven-segment encoder for one BCD digit.
 */
package bus_pkg;

    localparam int ADDR_W       = 13;
    localparam int RAM_ADDR_W   = 12;
    localparam int DATA_W       = 8;
    localparam int N_SLAVES     = 2;
    localparam int RAM_DEPTH    = 1 << RAM_ADDR_W;
    localparam int CNT_W        = $clog2(RAM_ADDR_W);
    localparam int BIT_W        = $clog2(DATA_W);
    localparam int FETCH_CYCLES = 2;
    localparam int BCD_W        = 12;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // Top address bit picks the slave, the rest is the RAM word address.
    typedef struct packed {
        bus_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
    } host_resp_t;

    // Segments active high, gfedcba.
    typedef struct packed {
        logic [6:0] hundreds;
        logic [6:0] tens;
        logic [6:0] ones;
    } seg_digits_t;

    typedef enum logic [2:0] {
        M_IDLE,
        M_GRANT,
        M_ADDR,
        M_WDATA,
        M_RDATA,
        M_DONE
    } master_state_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_WDATA,
        S_FETCH,
        S_RDATA,
        S_DONE
    } slave_state_e;

    function automatic logic [6:0] seg7_encode(input logic [3:0] digit);
        case (digit)
            4'd0:    return 7'h3f;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5b;
            4'd3:    return 7'h4f;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6d;
            4'd6:    return 7'h7d;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7f;
            4'd9:    return 7'h6f;
            default: return 7'h00;
        endcase
    endfunction

endpackage

//--- memory_slave/memory_slave.sv
/*
 * Memory slave: serial port, address and data buffers,
 * 4K x 8 RAM and three-digit display of the RAM output.
 */
`timescale 1ns/1ps

module memory_slave
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        select,
    input  logic        bus_util,
    input  logic        rd_wrt,
    input  logic        mosi,
    output logic        miso,
    output logic        miso_valid,
    output logic        busy,
    output seg_digits_t disp
);

    logic                  write_en;
    logic                  req_data;
    logic                  ram_we;
    logic [RAM_ADDR_W-1:0] port_addr;
    logic [DATA_W-1:0]     port_wdata;
    logic [RAM_ADDR_W-1:0] addr_buf;
    logic [DATA_W-1:0]     data_buf;
    logic [DATA_W-1:0]     ram_q;

    slave_port u_port (
        .clk        (clk),
        .rstn       (rstn),
        .select     (select),
        .bus_util   (bus_util),
        .rd_wrt     (rd_wrt),
        .mosi       (mosi),
        .rd_data    (ram_q),
        .miso       (miso),
        .miso_valid (miso_valid),
        .busy       (busy),
        .write_en   (write_en),
        .req_data   (req_data),
        .addr       (port_addr),
        .wr_data    (port_wdata)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ram_we <= 1'b0;
        end else begin
            ram_we <= write_en;
        end
    end

    // A write also needs its address captured.
    always_ff @(posedge clk) begin
        if (req_data || write_en) begin
            addr_buf <= port_addr;
        end
        if (write_en) begin
            data_buf <= port_wdata;
        end
    end

    ram_4k u_ram (
        .clk  (clk),
        .we   (ram_we),
        .addr (addr_buf),
        .din  (data_buf),
        .q    (ram_q)
    );

    bin_to_bcd u_disp (
        .din  (ram_q),
        .dout (disp)
    );

endmodule

//--- memory_slave/ram_4k.sv
/*
 * Single-port 4096 x 8 RAM, registered read, write-first.
 */
`timescale 1ns/1ps

module ram_4k
    import bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  we,
    input  logic [RAM_ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0]     din,
    output logic [DATA_W-1:0]     q
);

    logic [DATA_W-1:0] mem [RAM_DEPTH] = '{default: '0};

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
            q         <= din;
        end else begin
            q <= mem[addr];
        end
    end

endmodule

//--- memory_slave/slave_port.sv
/*
 * Slave side serial engine: deserializes address and write data,
 * issues write and fetch strobes, serializes read data onto miso.
 */
`timescale 1ns/1ps

module slave_port
    import bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  select,
    input  logic                  bus_util,
    input  logic                  rd_wrt,
    input  logic                  mosi,
    input  logic [DATA_W-1:0]     rd_data,
    output logic                  miso,
    output logic                  miso_valid,
    output logic                  busy,
    output logic                  write_en,
    output logic                  req_data,
    output logic [RAM_ADDR_W-1:0] addr,
    output logic [DATA_W-1:0]     wr_data
);

    slave_state_e     state;
    logic [CNT_W-1:0] bit_cnt;
    logic             active;

    assign active = select && bus_util;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            busy     <= 1'b0;
            write_en <= 1'b0;
            req_data <= 1'b0;
        end else begin
            write_en <= 1'b0;
            req_data <= 1'b0;
            if (!active && state != S_IDLE) begin
                busy  <= 1'b0;
                state <= S_IDLE;
            end else begin
                case (state)
                    S_IDLE: begin
                        if (active) begin
                            busy    <= 1'b1;
                            bit_cnt <= '0;
                            state   <= S_ADDR;
                        end
                    end
                    S_ADDR: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == CNT_W'(RAM_ADDR_W - 1)) begin
                            bit_cnt <= '0;
                            if (rd_wrt) begin
                                state <= S_WDATA;
                            end else begin
                                req_data <= 1'b1;
                                state    <= S_FETCH;
                            end
                        end
                    end
                    S_WDATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == CNT_W'(DATA_W - 1)) begin
                            write_en <= 1'b1;
                            state    <= S_DONE;
                        end
                    end
                    // Address buffer load plus one RAM read cycle.
                    S_FETCH: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == CNT_W'(FETCH_CYCLES - 1)) begin
                            bit_cnt <= '0;
                            state   <= S_RDATA;
                        end
                    end
                    S_RDATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == CNT_W'(DATA_W - 1)) begin
                            busy  <= 1'b0;
                            state <= S_DONE;
                        end
                    end
                    // Busy covers the RAM write that follows write_en.
                    S_DONE: busy <= write_en;
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_ADDR) begin
            addr <= {addr[RAM_ADDR_W-2:0], mosi};
        end
        if (state == S_WDATA) begin
            wr_data <= {wr_data[DATA_W-2:0], mosi};
        end
    end

    // RAM output is stable during the read, so bits are picked by index.
    assign miso_valid = (state == S_RDATA);
    assign miso       = miso_valid && rd_data[BIT_W'(DATA_W - 1) - bit_cnt[BIT_W-1:0]];

endmodule

//--- serial_bus_system.f
common/bus_pkg.sv
memory_slave/ram_4k.sv
source/bin_to_bcd.sv
memory_slave/slave_port.sv
memory_slave/memory_slave.sv
source/bus_master.sv
source/bus_controller.sv
source/serial_bus_system.sv
sim/serial_bus_chk.sv
sim/tb_serial_bus_system.sv

//--- sim/serial_bus_chk.sv
/*
 * Concurrent assertions on the serial bus protocol.
 * Bound into the bus controller and into each memory slave.
 */
`timescale 1ns/1ps

module serial_bus_chk #(
    parameter int SEL_W = 1
) (
    input logic             clk,
    input logic             rstn,
    input logic [SEL_W-1:0] select,
    input logic             bus_util,
    input logic             bus_req,
    input logic             bus_grant,
    input logic             write_en,
    input logic             rd_wrt
);

    assert property (@(posedge clk) disable iff (!rstn) $onehot0(select))
        else $error("select is not one-hot or zero");

    // Target and bus-in-use flag are frozen once the grant is out.
    assert property (@(posedge clk) disable iff (!rstn)
        (bus_grant && bus_req) |=> (!bus_req || ($stable(select) && $stable(bus_util))))
        else $error("select or bus_util changed while bus_req was high");

    assert property (@(posedge clk) disable iff (!rstn) $rose(write_en) |-> rd_wrt)
        else $error("write_en rose during a read transaction");

endmodule

bind bus_controller serial_bus_chk #(.SEL_W(bus_pkg::N_SLAVES)) u_ctrl_chk (
    .clk       (clk),
    .rstn      (rstn),
    .select    (select),
    .bus_util  (bus_util),
    .bus_req   (bus_req),
    .bus_grant (bus_grant),
    .write_en  (1'b0),
    .rd_wrt    (1'b0)
);

bind memory_slave serial_bus_chk #(.SEL_W(1)) u_slave_chk (
    .clk       (clk),
    .rstn      (rstn),
    .select    (select),
    .bus_util  (bus_util),
    .bus_req   (1'b0),
    .bus_grant (1'b0),
    .write_en  (write_en),
    .rd_wrt    (rd_wrt)
);

//--- sim/tb_serial_bus_system.sv
/*
 * Table-driven testbench for the serial memory bus.
 * Reference memory model, display checks and random traffic.
 */
`timescale 1ns/1ps

module tb_serial_bus_system
    import bus_pkg::*;
();

    typedef struct packed {
        bus_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              rnd;
    } step_t;

    logic                       clk;
    logic                       rstn;
    logic                       req_valid;
    host_req_t                  req;
    logic                       req_ready;
    logic                       resp_valid;
    host_resp_t                 resp;
    seg_digits_t [N_SLAVES-1:0] disp;

    step_t             steps[$];
    string             names[$];
    logic [DATA_W-1:0] ref_mem [2**ADDR_W];
    logic [DATA_W-1:0] shown [N_SLAVES];
    integer            seed = 32'h6f7;
    int                cycle_count = 0;
    int                cycle_limit = 100;
    int                error_count = 0;
    int                accept_count = 0;
    int                resp_count = 0;

    serial_bus_system UUT (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .disp       (disp)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (rstn && req_valid && req_ready) accept_count++;
        if (rstn && resp_valid) resp_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "Stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("ERROR: %s expected %0h actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic add_step(input string name, input bus_op_e op,
                            input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            input logic rnd);
        steps.push_back('{op, addr, wdata, rnd});
        names.push_back(name);
    endtask

    // Segments gfedcba, active high.
    function automatic logic [6:0] segment_for_digit(input int digit);
        case (digit)
            0:       return 7'h3f;
            1:       return 7'h06;
            2:       return 7'h5b;
            3:       return 7'h4f;
            4:       return 7'h66;
            5:       return 7'h6d;
            6:       return 7'h7d;
            7:       return 7'h07;
            8:       return 7'h7f;
            9:       return 7'h6f;
            default: return 7'h00;
        endcase
    endfunction

    function automatic logic [20:0] expected_digits(input logic [DATA_W-1:0] value);
        int n;
        n = int'(value);
        return {segment_for_digit(n / 100), segment_for_digit((n / 10) % 10),
                segment_for_digit(n % 10)};
    endfunction

    task automatic check_idle_outputs(input string name);
        check_value({name, "_req_ready"}, 0, 32'(req_ready));
        check_value({name, "_resp_valid"}, 0, 32'(resp_valid));
        for (int i = 0; i < N_SLAVES; i++) begin
            check_value({name, "_disp"}, 32'(expected_digits(8'h00)), 32'(disp[i]));
        end
    endtask

    task automatic check_display(input string name, input int target,
                                 input logic [DATA_W-1:0] word);
        int other;
        other = N_SLAVES - 1 - target;
        check_value({name, "_disp"}, 32'(expected_digits(word)), 32'(disp[target]));
        check_value({name, "_disp_other"}, 32'(expected_digits(shown[other])),
                    32'(disp[other]));
        shown[target] = word;
    endtask

    task automatic run_step(input int idx);
        step_t             s;
        logic [31:0]       r;
        logic [DATA_W-1:0] expected;
        int                target;
        s = steps[idx];
        if (s.rnd) begin
            r       = $random(seed);
            s.op    = bus_op_e'(r[0]);
            s.addr  = {r[8], 8'h00, r[4:1]};
            s.wdata = r[23:16];
        end
        // Request is held until the master is ready again.
        req_valid = 1'b1;
        req       = '{s.op, s.addr, s.wdata};
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        // Random steps keep req_valid high while the master is busy.
        if (!s.rnd) begin
            req_valid = 1'b0;
        end
        while (!resp_valid) @(negedge clk);
        req_valid = 1'b0;
        target = int'(s.addr[ADDR_W-1]);
        if (s.op == OP_WRITE) begin
            ref_mem[s.addr] = s.wdata;
        end
        expected = ref_mem[s.addr];
        check_value(names[idx], 32'(expected), 32'(resp.rdata));
        check_display(names[idx], target, expected);
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        for (int a = 0; a < 2**ADDR_W; a++) begin
            ref_mem[a] = '0;
        end
        for (int i = 0; i < N_SLAVES; i++) begin
            shown[i] = '0;
        end

        add_step("wr_s0", OP_WRITE, 13'h0005, 8'ha5, 1'b0);
        add_step("rd_s0", OP_READ, 13'h0005, 8'h00, 1'b0);
        add_step("wr_s1_same_addr", OP_WRITE, 13'h1005, 8'h3c, 1'b0);
        add_step("rd_s0_again", OP_READ, 13'h0005, 8'h00, 1'b0);
        add_step("rd_s1", OP_READ, 13'h1005, 8'h00, 1'b0);
        add_step("wr_s0_top", OP_WRITE, 13'h0fff, 8'hff, 1'b0);
        add_step("rd_s0_top", OP_READ, 13'h0fff, 8'h00, 1'b0);
        add_step("rd_s1_unwritten", OP_READ, 13'h1abc, 8'h00, 1'b0);
        add_step("wr_s1_mid", OP_WRITE, 13'h1800, 8'd99, 1'b0);
        add_step("rd_s1_mid", OP_READ, 13'h1800, 8'h00, 1'b0);
        for (int i = 0; i < 12; i++) begin
            add_step($sformatf("random_%0d", i), OP_READ, '0, '0, 1'b1);
        end
        cycle_limit = 40 * steps.size() + 100;

        repeat (5) begin
            @(negedge clk);
            check_idle_outputs("reset");
        end
        rstn = 1'b1;
        check_idle_outputs("after_reset");
        @(negedge clk);
        check_value("req_ready_rise", 1, 32'(req_ready));

        for (int i = 0; i < steps.size(); i++) begin
            run_step(i);
        end
        @(negedge clk);
        check_value("accept_count", 32'(steps.size()), 32'(accept_count));
        check_value("resp_count", 32'(steps.size()), 32'(resp_count));

        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- source/bin_to_bcd.sv
/*
 * 8-bit binary to three BCD digits by shift-and-add-3,
 * then to seven-segment patterns.
 */
`timescale 1ns/1ps

module bin_to_bcd
    import bus_pkg::*;
(
    input  logic [DATA_W-1:0] din,
    output seg_digits_t       dout
);

    logic [BCD_W-1:0] bcd;

    always_comb begin
        bcd = '0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            // Correct any digit of 5 or more before the next shift.
            for (int d = 0; d < BCD_W / 4; d++) begin
                if (bcd[4*d +: 4] >= 4'd5) begin
                    bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
                end
            end
            bcd = {bcd[BCD_W-2:0], din[i]};
        end
    end

    assign dout.hundreds = seg7_encode(bcd[11:8]);
    assign dout.tens     = seg7_encode(bcd[7:4]);
    assign dout.ones     = seg7_encode(bcd[3:0]);

endmodule

//--- source/bus_controller.sv
/*
 * Bus controller for a single master: registered grant,
 * one-hot slave select and the bus-in-use flag.
 */
`timescale 1ns/1ps

module bus_controller
    import bus_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,
    input  logic                bus_req,
    input  logic                slave_sel,
    output logic                bus_grant,
    output logic                bus_util,
    output logic [N_SLAVES-1:0] select
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bus_grant <= 1'b0;
            select    <= '0;
        end else begin
            bus_grant <= bus_req;
            // Target is fixed on the grant and held until release.
            if (!bus_req) begin
                select <= '0;
            end else if (!bus_grant) begin
                select <= N_SLAVES'(1) << slave_sel;
            end
        end
    end

    // Bus is in use exactly while a slave is selected.
    assign bus_util = |select;

endmodule

//--- source/bus_master.sv
/*
 * Bus master: accepts host requests, serializes address and write data
 * onto mosi and collects read data from miso.
 */
`timescale 1ns/1ps

module bus_master
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       req_valid,
    input  host_req_t  req,
    output logic       req_ready,
    output logic       resp_valid,
    output host_resp_t resp,
    output logic       bus_req,
    output logic       slave_sel,
    input  logic       bus_grant,
    output logic       rd_wrt,
    output logic       mosi,
    input  logic       miso,
    input  logic       miso_valid,
    input  logic       busy
);

    master_state_e                   state;
    host_req_t                       req_q;
    logic [RAM_ADDR_W+DATA_W-1:0]    tx_shift;
    logic [DATA_W-1:0]               rx_data;
    logic [CNT_W-1:0]                bit_cnt;
    logic                            accept;
    logic                            data_done;

    assign accept    = req_valid && req_ready;
    assign data_done = (bit_cnt == CNT_W'(DATA_W));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= M_IDLE;
            req_ready <= 1'b0;
            bit_cnt   <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    req_ready <= 1'b1;
                    if (accept) begin
                        req_ready <= 1'b0;
                        state     <= M_GRANT;
                    end
                end
                M_GRANT: begin
                    if (bus_grant) begin
                        bit_cnt <= '0;
                        state   <= M_ADDR;
                    end
                end
                M_ADDR: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(RAM_ADDR_W - 1)) begin
                        bit_cnt <= '0;
                        state   <= (req_q.op == OP_WRITE) ? M_WDATA : M_RDATA;
                    end
                end
                // Count data bits, then wait for the slave to finish.
                M_WDATA, M_RDATA: begin
                    if (!data_done) begin
                        if (state == M_WDATA || miso_valid) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (!busy) begin
                        state <= M_DONE;
                    end
                end
                M_DONE: begin
                    req_ready <= 1'b1;
                    state     <= M_IDLE;
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (state == M_GRANT && bus_grant) begin
            tx_shift <= {req_q.addr[RAM_ADDR_W-1:0], req_q.wdata};
        end else if (state == M_ADDR || state == M_WDATA) begin
            tx_shift <= tx_shift << 1;
        end
        if (state == M_RDATA && miso_valid && !data_done) begin
            rx_data <= {rx_data[DATA_W-2:0], miso};
        end
    end

    assign bus_req    = (state != M_IDLE) && (state != M_DONE);
    assign slave_sel  = req_q.addr[ADDR_W-1];
    assign rd_wrt     = bus_req && (req_q.op == OP_WRITE);
    assign mosi       = (state == M_ADDR || state == M_WDATA) && tx_shift[RAM_ADDR_W+DATA_W-1];
    assign resp_valid = (state == M_DONE);
    assign resp.rdata = (req_q.op == OP_WRITE) ? req_q.wdata : rx_data;

endmodule

//--- source/serial_bus_system.sv
/*
 * Top level: bus master, bus controller and two memory slaves
 * on a shared serial bus.
 */
`timescale 1ns/1ps

module serial_bus_system
    import bus_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       req_valid,
    input  host_req_t                  req,
    output logic                       req_ready,
    output logic                       resp_valid,
    output host_resp_t                 resp,
    output seg_digits_t [N_SLAVES-1:0] disp
);

    logic                bus_req;
    logic                slave_sel;
    logic                bus_grant;
    logic                bus_util;
    logic                rd_wrt;
    logic                mosi;
    logic [N_SLAVES-1:0] select;
    logic [N_SLAVES-1:0] slave_miso;
    logic [N_SLAVES-1:0] slave_miso_valid;
    logic [N_SLAVES-1:0] slave_busy;

    bus_master u_master (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .bus_req    (bus_req),
        .slave_sel  (slave_sel),
        .bus_grant  (bus_grant),
        .rd_wrt     (rd_wrt),
        .mosi       (mosi),
        .miso       (|slave_miso),
        .miso_valid (|slave_miso_valid),
        .busy       (|slave_busy)
    );

    bus_controller u_ctrl (
        .clk       (clk),
        .rstn      (rstn),
        .bus_req   (bus_req),
        .slave_sel (slave_sel),
        .bus_grant (bus_grant),
        .bus_util  (bus_util),
        .select    (select)
    );

    // Idle slaves drive zeros, so the return lines merge by OR.
    for (genvar i = 0; i < N_SLAVES; i++) begin : g_slave
        memory_slave u_slave (
            .clk        (clk),
            .rstn       (rstn),
            .select     (select[i]),
            .bus_util   (bus_util),
            .rd_wrt     (rd_wrt),
            .mosi       (mosi),
            .miso       (slave_miso[i]),
            .miso_valid (slave_miso_valid[i]),
            .busy       (slave_busy[i]),
            .disp       (disp[i])
        );
    end

endmodule
